// File: rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_BEQ     = 6'b000100,
        OP_ADDIU   = 6'b001001,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } opcode_e;

    // funct field values under OP_SPECIAL
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001
    } funct_e;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_type_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_type_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [25:0] target;
    } j_type_t;

    // one instruction word seen through all three encodings
    typedef union packed {
        i_type_t i_type;
        r_type_t r_type;
        j_type_t j_type;
    } instr_u;

    typedef enum logic [1:0] {
        ALU_ADD    = 2'b00,
        ALU_SUB    = 2'b01,
        ALU_PASS_B = 2'b10
    } alu_op_e;

    // address 0 is kept free as the halt target
    localparam logic [31:0] RESET_PC    = 32'h0000_0004;
    // first byte of the result block written by the test program
    localparam logic [31:0] RESULT_BASE = 32'h0000_0480;

endpackage

`default_nettype wire

// File: rtl/mips_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module mips_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  read_reg_a,
    input  logic [4:0]  read_reg_b,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    input  logic [4:0]  write_reg,
    input  logic [31:0] write_data,
    input  logic        write_enable,
    output logic [31:0] register_v0
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= 32'd0;
            end
        end else if (write_enable && write_reg != 5'd0) begin
            // r0 is never written, so it keeps the value from reset
            regs[write_reg] <= write_data;
        end
    end

    // combinational reads
    assign read_data_a = regs[read_reg_a];
    assign read_data_b = regs[read_reg_b];
    assign register_v0 = regs[2];

    // r0 reads zero on both ports once out of reset
    a_zero_reg: assert property (@(posedge clk) disable iff (!rst_n)
        (read_reg_a == 5'd0 |-> read_data_a == 32'd0)
        and (read_reg_b == 5'd0 |-> read_data_b == 32'd0));

endmodule

`default_nettype wire

// File: rtl/mips_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module mips_decoder (
    input  mips_pkg::instr_u  instr,
    output logic              reg_write,
    output logic              mem_read,
    output logic              mem_write,
    output logic              alu_src_imm,
    output logic              reg_dst_rd,
    output logic              branch_eq,
    output logic              jump,
    output logic              jump_reg,
    output mips_pkg::alu_op_e alu_op,
    output logic [31:0]       imm_ext,
    output logic              illegal
);

    // sign-extended immediate for addiu, lw, sw and beq
    assign imm_ext = {{16{instr.i_type.imm[15]}}, instr.i_type.imm};

    always_comb begin
        // everything off unless the opcode asks for it
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        reg_dst_rd  = 1'b0;
        branch_eq   = 1'b0;
        jump        = 1'b0;
        jump_reg    = 1'b0;
        alu_op      = mips_pkg::ALU_PASS_B;
        illegal     = 1'b0;
        case (instr.r_type.opcode)
            mips_pkg::OP_SPECIAL: begin
                // r-type, the funct field picks the operation
                case (instr.r_type.funct)
                    mips_pkg::FN_ADDU: begin
                        reg_write  = 1'b1;
                        reg_dst_rd = 1'b1;
                        alu_op     = mips_pkg::ALU_ADD;
                    end
                    mips_pkg::FN_JR: begin
                        jump_reg = 1'b1;
                    end
                    default: begin
                        illegal = 1'b1;
                    end
                endcase
            end
            mips_pkg::OP_J: begin
                jump = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                // rs - rt, taken when the alu reports zero
                branch_eq = 1'b1;
                alu_op    = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_ADDIU: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_LW: begin
                // address is rs + imm, data lands in rt
                reg_write   = 1'b1;
                mem_read    = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_SW: begin
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = mips_pkg::ALU_ADD;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/mips_alu.sv
`timescale 1ns/100ps
`default_nettype none

module mips_alu (
    input  mips_pkg::alu_op_e alu_op,
    input  logic [31:0]       operand_a,
    input  logic [31:0]       operand_b,
    output logic [31:0]       result,
    output logic              zero
);

    always_comb begin
        case (alu_op)
            // addiu, addu and load/store address generation
            mips_pkg::ALU_ADD: begin
                result = operand_a + operand_b;
            end
            // beq compares by subtracting
            mips_pkg::ALU_SUB: begin
                result = operand_a - operand_b;
            end
            mips_pkg::ALU_PASS_B: begin
                result = operand_b;
            end
            default: begin
                result = operand_b;
            end
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// File: rtl/mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata,
    output logic        active,
    output logic [31:0] register_v0
);

    mips_pkg::instr_u  instr;
    mips_pkg::alu_op_e alu_op;
    logic        reg_write, mem_read, mem_write, alu_src_imm, reg_dst_rd;
    logic        branch_eq, jump, jump_reg, illegal;
    logic [31:0] imm_ext;
    logic [31:0] read_data_a, read_data_b;
    logic [31:0] alu_operand_b, alu_result;
    logic        alu_zero;
    logic [4:0]  write_reg;
    logic [31:0] write_data;
    logic [31:0] pc, pc_plus4, branch_target, jump_target, next_pc;
    logic        active_q, halted_q, halt_now;

    assign instr = instr_readdata;

    mips_decoder u_decoder (
        .instr(instr), .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
        .alu_src_imm(alu_src_imm), .reg_dst_rd(reg_dst_rd), .branch_eq(branch_eq),
        .jump(jump), .jump_reg(jump_reg), .alu_op(alu_op), .imm_ext(imm_ext),
        .illegal(illegal)
    );

    // rd for r-type results and rt for addiu and lw
    assign write_reg  = reg_dst_rd ? instr.r_type.rd : instr.r_type.rt;
    assign write_data = mem_read ? data_readdata : alu_result;

    mips_regfile u_regfile (
        .clk(clk), .rst_n(rst_n),
        .read_reg_a(instr.r_type.rs), .read_reg_b(instr.r_type.rt),
        .read_data_a(read_data_a), .read_data_b(read_data_b),
        .write_reg(write_reg), .write_data(write_data),
        .write_enable(reg_write && active_q), .register_v0(register_v0)
    );

    assign alu_operand_b = alu_src_imm ? imm_ext : read_data_b;

    mips_alu u_alu (
        .alu_op(alu_op), .operand_a(read_data_a), .operand_b(alu_operand_b),
        .result(alu_result), .zero(alu_zero)
    );

    // all memory writes are gated while the core is idle
    assign data_address   = alu_result;
    assign data_writedata = read_data_b;
    assign data_write     = mem_write && active_q;
    assign data_read      = mem_read && active_q;

    // next pc candidates without a delay slot
    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], instr.j_type.target, 2'b00};

    // jr to address 0 or an unknown encoding ends the program
    assign halt_now = active_q && ((jump_reg && read_data_a == 32'd0) || illegal);

    always_comb begin
        if (halt_now) begin
            next_pc = 32'd0;
        end else if (jump_reg) begin
            next_pc = read_data_a;
        end else if (jump) begin
            next_pc = jump_target;
        end else if (branch_eq && alu_zero) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= mips_pkg::RESET_PC;
            active_q <= 1'b0;
            halted_q <= 1'b0;
        end else if (active_q) begin
            pc <= next_pc;
            if (halt_now) begin
                active_q <= 1'b0;
                halted_q <= 1'b1;
            end
        end else if (!halted_q) begin
            // first edge after reset starts execution at RESET_PC
            active_q <= 1'b1;
        end
    end

    assign instr_address = pc;
    assign active        = active_q;

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        active_q |-> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rtl/mips_instr_rom.sv
`timescale 1ns/100ps
`default_nettype none

module mips_instr_rom #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic [31:0] instr_address,
    output logic [31:0] instr_readdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [31:0] rom [0:DEPTH-1];

    // builds an i-type word
    function automatic mips_pkg::instr_u make_i(
        mips_pkg::opcode_e op,
        logic [4:0]        rs,
        logic [4:0]        rt,
        logic [15:0]       imm
    );
        mips_pkg::instr_u word;
        word = '0;
        word.i_type.opcode = op;
        word.i_type.rs     = rs;
        word.i_type.rt     = rt;
        word.i_type.imm    = imm;
        return word;
    endfunction

    initial begin
        mips_pkg::instr_u word;
        int unsigned      w;
        // unused words decode as illegal, so a stray fetch halts the core
        for (int k = 0; k < DEPTH; k++) begin
            rom[k] = '0;
        end
        w = mips_pkg::RESET_PC >> 2;
        // lw ri, 4i(r0) pulls the preloaded series into r2..r31
        for (int i = 2; i < 32; i++) begin
            rom[w] = make_i(mips_pkg::OP_LW, 5'd0, 5'(i), 16'(4 * i));
            w++;
        end
        // addiu ri, ri, 0x1111*(i-2)
        // only the low 16 bits of the step fit, and the core sign-extends them
        for (int i = 2; i < 32; i++) begin
            rom[w] = make_i(mips_pkg::OP_ADDIU, 5'(i), 5'(i), 16'(32'h1111 * (i - 2)));
            w++;
        end
        // sw ri, RESULT_BASE+4i(r0)
        for (int i = 2; i < 32; i++) begin
            rom[w] = make_i(mips_pkg::OP_SW, 5'd0, 5'(i),
                            16'(mips_pkg::RESULT_BASE + 32'(4 * i)));
            w++;
        end
        // jr r0 ends the program
        word = '0;
        word.r_type.opcode = mips_pkg::OP_SPECIAL;
        word.r_type.rs     = 5'd0;
        word.r_type.funct  = mips_pkg::FN_JR;
        rom[w] = word;
    end

    // word index, wrapping at the memory depth
    assign instr_readdata = rom[instr_address[ADDR_WIDTH+1:2]];

endmodule

`default_nettype wire

// File: rtl/mips_data_ram.sv
`timescale 1ns/100ps
`default_nettype none

module mips_data_ram #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic        clk,
    input  logic [31:0] data_address,
    input  logic        data_write,
    input  logic        data_read,
    input  logic [31:0] data_writedata,
    output logic [31:0] data_readdata,
    input  logic [31:0] dbg_address,
    output logic [31:0] dbg_readdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    logic [31:0] mem [0:DEPTH-1];

    // word k holds k, which is the series the program loads
    initial begin
        for (int k = 0; k < DEPTH; k++) begin
            mem[k] = 32'(k);
        end
    end

    always_ff @(posedge clk) begin
        if (data_write) begin
            mem[data_address[ADDR_WIDTH+1:2]] <= data_writedata;
        end
    end

    // core port reads only while a load is in flight
    assign data_readdata = data_read ? mem[data_address[ADDR_WIDTH+1:2]] : 32'd0;
    // host inspection port, read only
    assign dbg_readdata = mem[dbg_address[ADDR_WIDTH+1:2]];

    // no byte or halfword stores exist in this core
    a_write_aligned: assert property (@(posedge clk) data_write |-> data_address[1:0] == 2'b00);
    // stores belong to the result block and never touch the source series
    a_write_region: assert property (@(posedge clk)
        data_write |-> data_address >= mips_pkg::RESULT_BASE);

endmodule

`default_nettype wire

// File: rtl/mips_top.sv
`timescale 1ns/100ps
`default_nettype none

module mips_top #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic        active,
    output logic [31:0] register_v0,
    input  logic [31:0] dbg_address,
    output logic [31:0] dbg_readdata
);

    // core to memory wires
    logic [31:0] instr_address, instr_readdata;
    logic [31:0] data_address, data_writedata, data_readdata;
    logic        data_write, data_read;

    mips_core u_core (
        .clk(clk), .rst_n(rst_n),
        .instr_address(instr_address), .instr_readdata(instr_readdata),
        .data_address(data_address), .data_write(data_write), .data_read(data_read),
        .data_writedata(data_writedata), .data_readdata(data_readdata),
        .active(active), .register_v0(register_v0)
    );

    mips_instr_rom #(.ADDR_WIDTH(ADDR_WIDTH)) u_instr_rom (
        .instr_address(instr_address), .instr_readdata(instr_readdata)
    );

    // data memory also serves the host inspection port
    mips_data_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_data_ram (
        .clk(clk), .data_address(data_address), .data_write(data_write),
        .data_read(data_read), .data_writedata(data_writedata),
        .data_readdata(data_readdata), .dbg_address(dbg_address),
        .dbg_readdata(dbg_readdata)
    );

endmodule

`default_nettype wire

// File: tests/mips_top_tb.sv
`timescale 1ns/100ps
`default_nettype none

module mips_top_tb;

    localparam int ADDR_WIDTH     = 12;
    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    // thirty lw, thirty addiu, thirty sw and the final jr
    localparam int PROGRAM_CYCLES = 3 * 30 + 1;
    localparam int POST_HALT      = 8;
    localparam int MID_RUN_CYCLES = 40;
    // 30 results, 32 source words, 3 words around the result block
    localparam int TABLE_LEN      = 30 + 32 + 3;
    // three resets, two full runs with table read-back, one partial run
    localparam int TIMEOUT_CYCLES = 3 * RESET_CYCLES
                                  + 2 * (PROGRAM_CYCLES + 50 + TABLE_LEN)
                                  + MID_RUN_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] dbg_address;
    logic [31:0] dbg_readdata;

    // expected memory image with one address and word per entry
    logic [31:0] entry_address [0:TABLE_LEN-1];
    logic [31:0] entry_word    [0:TABLE_LEN-1];

    int value_errors;
    int other_errors;
    int cycle_count;
    int first_count;
    int second_count;

    mips_top #(.ADDR_WIDTH(ADDR_WIDTH)) UUT (
        .clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
        .dbg_address(dbg_address), .dbg_readdata(dbg_readdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // addiu carries only the low 16 bits of the step and sign-extends them
    function automatic logic [31:0] expected_result(input int i);
        logic [31:0] step;
        logic [15:0] imm;
        step = 32'h1111 * 32'(i - 2);
        imm  = step[15:0];
        return 32'(i) + {{16{imm[15]}}, imm};
    endfunction

    task automatic build_table();
        int n;
        n = 0;
        // register i is stored at RESULT_BASE + 4i
        for (int i = 2; i < 32; i++) begin
            entry_address[n] = mips_pkg::RESULT_BASE + 32'(4 * i);
            entry_word[n]    = expected_result(i);
            n++;
        end
        // word k of the source series is preloaded with k
        for (int i = 0; i < 32; i++) begin
            entry_address[n] = 32'(4 * i);
            entry_word[n]    = 32'(i);
            n++;
        end
        // slots 0 and 1 of the result block and the word just past it stay untouched
        entry_address[n] = mips_pkg::RESULT_BASE;
        entry_word[n]    = mips_pkg::RESULT_BASE >> 2;
        n++;
        entry_address[n] = mips_pkg::RESULT_BASE + 32'd4;
        entry_word[n]    = (mips_pkg::RESULT_BASE >> 2) + 32'd1;
        n++;
        entry_address[n] = mips_pkg::RESULT_BASE + 32'(4 * 32);
        entry_word[n]    = (mips_pkg::RESULT_BASE >> 2) + 32'd32;
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            value_errors++;
        end
    endtask

    // drives reset a little after the edge and checks idle outputs mid-cycle
    task automatic reset_core();
        @(posedge clk);
        #2 rst_n = 1'b0;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge clk);
            // the first reset edge has not happened yet at c == 0
            if (c > 0) begin
                compare_value("active during reset", {31'd0, active}, 32'd0);
                compare_value("register_v0 during reset", register_v0, 32'd0);
            end
            @(posedge clk);
        end
        #2 rst_n = 1'b1;
        // returns on the first edge that sees rst_n high
        @(posedge clk);
    endtask

    // counts the cycles with active high until the halt
    task automatic wait_for_halt(output int cycles);
        cycles = 0;
        @(negedge clk);
        compare_value("active on first cycle after reset", {31'd0, active}, 32'd1);
        while (active === 1'b1) begin
            cycles++;
            @(negedge clk);
        end
        if (cycles < PROGRAM_CYCLES) begin
            $display("core halted too early, after %0d of %0d cycles", cycles,
                     PROGRAM_CYCLES);
            other_errors++;
        end else begin
            compare_value("active cycle count", 32'(cycles), 32'(PROGRAM_CYCLES));
        end
        // halt is sticky and r2 keeps its final value
        for (int c = 0; c < POST_HALT; c++) begin
            compare_value("active after halt", {31'd0, active}, 32'd0);
            @(negedge clk);
        end
        compare_value("register_v0 after halt", register_v0, expected_result(2));
    endtask

    // one table entry per cycle through the inspection port
    task automatic read_back_memory();
        for (int e = 0; e < TABLE_LEN; e++) begin
            @(posedge clk);
            #2 dbg_address = entry_address[e];
            @(negedge clk);
            compare_value($sformatf("dbg_readdata @ 0x%03h", entry_address[e]),
                          dbg_readdata, entry_word[e]);
            compare_value("active while halted", {31'd0, active}, 32'd0);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the core never halted", cycle_count);
            other_errors++;
            $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        rst_n        = 1'b0;
        dbg_address  = 32'd0;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        build_table();

        // first run from power-up
        reset_core();
        wait_for_halt(first_count);
        read_back_memory();

        // restart and interrupt during the load/add phase before a full run
        reset_core();
        for (int c = 0; c < MID_RUN_CYCLES; c++) begin
            @(negedge clk);
            compare_value("active before mid-run reset", {31'd0, active}, 32'd1);
        end
        reset_core();
        wait_for_halt(second_count);
        compare_value("second run cycle count", 32'(second_count), 32'(first_count));
        read_back_memory();

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/mips_pkg.sv
rtl/mips_regfile.sv
rtl/mips_decoder.sv
rtl/mips_alu.sv
rtl/mips_core.sv
rtl/mips_instr_rom.sv
rtl/mips_data_ram.sv
rtl/mips_top.sv
tests/mips_top_tb.sv

// File: Makefile
# Verilator build and run for the MIPS core testbench
# any variable below can be overridden, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= mips_top_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TESTBENCH PASSED

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv) $(wildcard tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# success needs a clean exit and the pass line in the output
run: compile
	@out="$$($(SIM))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx "$(PASS_TEXT)"; then \
		exit 0; else exit 1; fi

clean:
	rm -rf $(BUILD_DIR)
